// ==== rtl/ohci_list_pkg.sv ====
/* shared types for the OHCI list scheduler; ED/TD addresses are 16-byte aligned
   and carried without the low nibble, register port is AXI4-Lite with 8-bit offsets */
package ohci_list_pkg;

  // endpoint type, upper bit clear for the periodic lists
  typedef enum logic [1:0] {
    ISOCHRONOUS = 2'b00,
    INTERRUPT   = 2'b01,
    CONTROL     = 2'b10,
    BULK        = 2'b11
  } channel_e;

  // ED or TD address bits 31:4
  typedef logic [27:0] ed_addr_t;

  // control/bulk service ratio minus one
  typedef logic [1:0] ratio_t;

  // AXI4-Lite field widths
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  // fetch request toward the DMA
  typedef struct packed {
    ed_addr_t address;
    channel_e channel;
    logic     is_ed;
  } dma_req_t;

  // item offered by the list walker
  typedef struct packed {
    ed_addr_t address;
    channel_e channel;
    logic     is_ed;
  } nextis_t;

  // master to slave
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

  // operational register offsets
  localparam axil_addr_t REG_CONTROL         = 8'h00;
  localparam axil_addr_t REG_CONTROL_HEAD    = 8'h04;
  localparam axil_addr_t REG_CONTROL_CURRENT = 8'h08;
  localparam axil_addr_t REG_BULK_HEAD       = 8'h0C;
  localparam axil_addr_t REG_BULK_CURRENT    = 8'h10;
  localparam axil_addr_t REG_PERIOD_CURRENT  = 8'h14;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== rtl/ohci_op_regs.sv ====
/* AXI4-Lite slave, one outstanding write and one outstanding read; unmapped
   offsets answer SLVERR, reads return zero there and writes are dropped */
`timescale 1ns/10ps

module ohci_op_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ohci_list_pkg::axil_req_t axil_req_i,
  output ohci_list_pkg::axil_rsp_t axil_rsp_o,
  input  logic                     ctrl_cur_we_i,
  input  logic                     bulk_cur_we_i,
  input  logic                     period_cur_we_i,
  input  ohci_list_pkg::ed_addr_t  cur_d_i,
  output ohci_list_pkg::ratio_t    ratio_o,
  output logic                     frame_periodic_o,
  output ohci_list_pkg::ed_addr_t  ctrl_head_o,
  output ohci_list_pkg::ed_addr_t  bulk_head_o,
  output ohci_list_pkg::ed_addr_t  ctrl_cur_o,
  output ohci_list_pkg::ed_addr_t  bulk_cur_o,
  output ohci_list_pkg::ed_addr_t  period_cur_o
);
  import ohci_list_pkg::*;

  logic       aw_held_q;
  logic       w_held_q;
  axil_addr_t aw_addr_q;
  axil_data_t w_data_q;
  logic       aw_fire;
  logic       w_fire;
  logic       wr_fire;
  axil_addr_t wr_addr;
  axil_data_t wr_data;
  logic       wr_hit;
  logic       bvalid_q;
  axil_resp_t bresp_q;
  logic       ar_fire;
  logic       rd_hit;
  axil_data_t rd_data;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_resp_t rresp_q;
  ratio_t     ratio_q;
  logic       frame_periodic_q;
  ed_addr_t   ctrl_head_q;
  ed_addr_t   bulk_head_q;
  ed_addr_t   ctrl_cur_q;
  ed_addr_t   bulk_cur_q;
  ed_addr_t   period_cur_q;

  // AW and W accepted independently, each held until its partner shows up
  assign aw_fire = axil_req_i.awvalid && axil_rsp_o.awready;
  assign w_fire  = axil_req_i.wvalid && axil_rsp_o.wready;
  assign wr_fire = (aw_held_q || aw_fire) && (w_held_q || w_fire);
  // held copy first, else the live channel
  assign wr_addr = aw_held_q ? aw_addr_q : axil_req_i.awaddr;
  assign wr_data = w_held_q ? w_data_q : axil_req_i.wdata;
  assign wr_hit  = wr_addr inside {REG_CONTROL, REG_CONTROL_HEAD, REG_CONTROL_CURRENT,
                                   REG_BULK_HEAD, REG_BULK_CURRENT, REG_PERIOD_CURRENT};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= RESP_OKAY;
    end else if (wr_fire) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      bvalid_q  <= 1'b1;
      bresp_q   <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end else begin
      if (aw_fire) aw_held_q <= 1'b1;
      if (w_fire) w_held_q <= 1'b1;
      if (bvalid_q && axil_req_i.bready) bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) aw_addr_q <= axil_req_i.awaddr;
    if (w_fire) w_data_q <= axil_req_i.wdata;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ratio_q          <= '0;
      frame_periodic_q <= 1'b0;
      ctrl_head_q      <= '0;
      bulk_head_q      <= '0;
      ctrl_cur_q       <= '0;
      bulk_cur_q       <= '0;
      period_cur_q     <= '0;
    end else begin
      if (wr_fire) begin
        case (wr_addr)
          REG_CONTROL: begin
            ratio_q          <= wr_data[1:0];
            frame_periodic_q <= wr_data[2];
          end
          REG_CONTROL_HEAD:    ctrl_head_q  <= wr_data[31:4];
          REG_CONTROL_CURRENT: ctrl_cur_q   <= wr_data[31:4];
          REG_BULK_HEAD:       bulk_head_q  <= wr_data[31:4];
          REG_BULK_CURRENT:    bulk_cur_q   <= wr_data[31:4];
          REG_PERIOD_CURRENT:  period_cur_q <= wr_data[31:4];
          default: ;
        endcase
      end
      // list service updates come last so they beat a bus write
      if (ctrl_cur_we_i) ctrl_cur_q <= cur_d_i;
      if (bulk_cur_we_i) bulk_cur_q <= cur_d_i;
      if (period_cur_we_i) period_cur_q <= cur_d_i;
    end
  end

  // read decode, pointer low nibble reads zero
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (axil_req_i.araddr)
      REG_CONTROL:         rd_data = {29'd0, frame_periodic_q, ratio_q};
      REG_CONTROL_HEAD:    rd_data = {ctrl_head_q, 4'h0};
      REG_CONTROL_CURRENT: rd_data = {ctrl_cur_q, 4'h0};
      REG_BULK_HEAD:       rd_data = {bulk_head_q, 4'h0};
      REG_BULK_CURRENT:    rd_data = {bulk_cur_q, 4'h0};
      REG_PERIOD_CURRENT:  rd_data = {period_cur_q, 4'h0};
      default:             rd_hit  = 1'b0;
    endcase
  end

  assign ar_fire = axil_req_i.arvalid && axil_rsp_o.arready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else if (ar_fire) rvalid_q <= 1'b1;
    else if (axil_req_i.rready) rvalid_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // no new write address or data while a response waits
  assign axil_rsp_o.awready = !aw_held_q && !bvalid_q;
  assign axil_rsp_o.wready  = !w_held_q && !bvalid_q;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.arready = !rvalid_q;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;

  assign ratio_o          = ratio_q;
  assign frame_periodic_o = frame_periodic_q;
  assign ctrl_head_o      = ctrl_head_q;
  assign bulk_head_o      = bulk_head_q;
  assign ctrl_cur_o       = ctrl_cur_q;
  assign bulk_cur_o       = bulk_cur_q;
  assign period_cur_o     = period_cur_q;

  // write response stays up with the same code until the master takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid && $stable(axil_rsp_o.bresp));

endmodule

// ==== rtl/ohci_list_service.sv ====
/* start_i must stay low during reset; a start while heads are still being sent is
   ignored, and nextis items are taken at most every second cycle */
`timescale 1ns/10ps

module ohci_list_service (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  logic                    frame_periodic_i,
  input  logic                    counter_is_threshold_i,
  input  logic                    nextis_valid_i,
  input  ohci_list_pkg::nextis_t  nextis_i,
  output logic                    nextis_ready_o,
  input  ohci_list_pkg::ed_addr_t ctrl_head_i,
  input  ohci_list_pkg::ed_addr_t bulk_head_i,
  input  ohci_list_pkg::ed_addr_t ctrl_cur_i,
  input  ohci_list_pkg::ed_addr_t bulk_cur_i,
  input  ohci_list_pkg::ed_addr_t period_cur_i,
  output logic                    ctrl_cur_we_o,
  output logic                    bulk_cur_we_o,
  output logic                    period_cur_we_o,
  output ohci_list_pkg::ed_addr_t cur_d_o,
  output logic                    req_valid_o,
  output ohci_list_pkg::dma_req_t req_o,
  input  logic                    req_ready_i
);
  import ohci_list_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CTRL_HEAD,
    BULK_HEAD
  } head_state_e;

  head_state_e state_q;
  head_state_e state_d;
  logic        nextis_fire;
  logic        send_ctrl_head;
  logic        send_bulk_head;
  logic        periodic_type;
  logic        zone_match;
  logic        ed_update;
  logic        nextis_ready_d;

  assign nextis_fire   = nextis_valid_i && nextis_ready_o;
  // periodic types have the upper channel bit clear
  assign periodic_type = ~nextis_i.channel[1];
  assign zone_match    = (periodic_type == frame_periodic_i);
  // matching ED refreshes its own current pointer
  assign ed_update     = nextis_fire && nextis_i.is_ed && zone_match;

  // control head goes out straight on start unless a walker item takes the slot
  assign send_ctrl_head = (state_q == CTRL_HEAD) ||
                          ((state_q == IDLE) && start_i && !nextis_fire);
  assign send_bulk_head = (state_q == BULK_HEAD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) state_d = (send_ctrl_head && req_ready_i) ? BULK_HEAD : CTRL_HEAD;
      end
      CTRL_HEAD: begin
        if (req_ready_i) state_d = BULK_HEAD;
      end
      BULK_HEAD: begin
        if (req_ready_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  // request mux, heads first, then walker items
  always_comb begin
    req_valid_o   = 1'b0;
    req_o.address = nextis_i.address;
    req_o.channel = nextis_i.channel;
    req_o.is_ed   = nextis_i.is_ed;
    if (send_ctrl_head) begin
      req_valid_o   = 1'b1;
      req_o.address = ctrl_head_i;
      req_o.channel = CONTROL;
      req_o.is_ed   = 1'b1;
    end else if (send_bulk_head) begin
      req_valid_o   = 1'b1;
      req_o.address = bulk_head_i;
      req_o.channel = BULK;
      req_o.is_ed   = 1'b1;
    end else if (nextis_fire) begin
      req_valid_o = 1'b1;
      // wrong zone, resume the list that should run now
      if (nextis_i.is_ed && !zone_match) begin
        if (frame_periodic_i) begin
          req_o.address = period_cur_i;
          req_o.channel = INTERRUPT;
        end else if (counter_is_threshold_i) begin
          req_o.address = bulk_cur_i;
          req_o.channel = BULK;
        end else begin
          req_o.address = ctrl_cur_i;
          req_o.channel = CONTROL;
        end
      end
    end
  end

  // current pointers load from the head once its request is taken
  assign ctrl_cur_we_o   = (send_ctrl_head && req_ready_i) ||
                           (ed_update && (nextis_i.channel == CONTROL));
  assign bulk_cur_we_o   = (send_bulk_head && req_ready_i) ||
                           (ed_update && (nextis_i.channel == BULK));
  assign period_cur_we_o = ed_update && periodic_type;
  // only heads and matching EDs are written, both carry their own address
  assign cur_d_o         = req_o.address;

  // ready next cycle only if no head is due and the stage will be empty
  assign nextis_ready_d = (state_d == IDLE) && req_ready_i && !req_valid_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= IDLE;
      nextis_ready_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      nextis_ready_o <= nextis_ready_d;
    end
  end

  assert property (@(posedge clk_i) !rst_n_i |-> !req_valid_o);

  // a walker item always finds room in the request stage
  assert property (@(posedge clk_i) disable iff (!rst_n_i) nextis_fire |-> req_ready_i);

endmodule

// ==== rtl/ohci_dma_request.sv ====
/* single-entry request register toward the DMA; ratio counter advances on
   DMA acceptance of EDs only, TDs leave it alone */
`timescale 1ns/10ps

module ohci_dma_request (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  ohci_list_pkg::dma_req_t req_i,
  output logic                    req_ready_o,
  input  ohci_list_pkg::ratio_t   ratio_i,
  output logic                    dma_valid_o,
  output ohci_list_pkg::dma_req_t dma_req_o,
  input  logic                    dma_ready_i,
  output logic                    counter_is_threshold_o
);
  import ohci_list_pkg::*;

  logic     valid_q;
  dma_req_t req_q;
  logic     dma_fire;
  ratio_t   ctrl_cnt_q;
  logic     threshold_q;

  // empty, or draining this cycle, so refill in the same cycle
  assign req_ready_o = !valid_q || dma_ready_i;
  assign dma_fire    = valid_q && dma_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) valid_q <= 1'b0;
    else if (req_ready_o) valid_q <= req_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) req_q <= req_i;
  end

  // threshold once ratio_i+1 control EDs went out, bulk ED restarts the count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_cnt_q  <= '0;
      threshold_q <= 1'b0;
    end else if (dma_fire && req_q.is_ed) begin
      if (req_q.channel == BULK) begin
        ctrl_cnt_q  <= '0;
        threshold_q <= 1'b0;
      end else if (req_q.channel == CONTROL) begin
        if (ctrl_cnt_q == ratio_i) threshold_q <= 1'b1;
        else ctrl_cnt_q <= ctrl_cnt_q + 2'd1;
      end
    end
  end

  assign dma_valid_o            = valid_q;
  assign dma_req_o              = req_q;
  assign counter_is_threshold_o = threshold_q;

  // stalled request keeps its payload
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_valid_o && !dma_ready_i |=> dma_valid_o && $stable(dma_req_o));

endmodule

// ==== rtl/ohci_list_top.sv ====
/* list scheduling core; the list walker and DMA engine sit outside and
   attach through the nextis and DMA request ports */
`timescale 1ns/10ps

module ohci_list_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ohci_list_pkg::axil_req_t axil_req_i,
  output ohci_list_pkg::axil_rsp_t axil_rsp_o,
  input  logic                     start_i,
  input  logic                     nextis_valid_i,
  input  ohci_list_pkg::nextis_t   nextis_i,
  output logic                     nextis_ready_o,
  output logic                     dma_valid_o,
  output ohci_list_pkg::dma_req_t  dma_req_o,
  input  logic                     dma_ready_i
);
  import ohci_list_pkg::*;

  // pointer update path, service to register file
  logic     ctrl_cur_we;
  logic     bulk_cur_we;
  logic     period_cur_we;
  ed_addr_t cur_d;
  // register file state seen by the service
  ratio_t   ratio;
  logic     frame_periodic;
  ed_addr_t ctrl_head;
  ed_addr_t bulk_head;
  ed_addr_t ctrl_cur;
  ed_addr_t bulk_cur;
  ed_addr_t period_cur;
  // service to request stage
  logic     req_valid;
  dma_req_t req;
  logic     req_ready;
  logic     counter_is_threshold;

  ohci_op_regs i_op_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .axil_req_i       (axil_req_i),
    .axil_rsp_o       (axil_rsp_o),
    .ctrl_cur_we_i    (ctrl_cur_we),
    .bulk_cur_we_i    (bulk_cur_we),
    .period_cur_we_i  (period_cur_we),
    .cur_d_i          (cur_d),
    .ratio_o          (ratio),
    .frame_periodic_o (frame_periodic),
    .ctrl_head_o      (ctrl_head),
    .bulk_head_o      (bulk_head),
    .ctrl_cur_o       (ctrl_cur),
    .bulk_cur_o       (bulk_cur),
    .period_cur_o     (period_cur)
  );

  ohci_list_service i_list_service (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .start_i                (start_i),
    .frame_periodic_i       (frame_periodic),
    .counter_is_threshold_i (counter_is_threshold),
    .nextis_valid_i         (nextis_valid_i),
    .nextis_i               (nextis_i),
    .nextis_ready_o         (nextis_ready_o),
    .ctrl_head_i            (ctrl_head),
    .bulk_head_i            (bulk_head),
    .ctrl_cur_i             (ctrl_cur),
    .bulk_cur_i             (bulk_cur),
    .period_cur_i           (period_cur),
    .ctrl_cur_we_o          (ctrl_cur_we),
    .bulk_cur_we_o          (bulk_cur_we),
    .period_cur_we_o        (period_cur_we),
    .cur_d_o                (cur_d),
    .req_valid_o            (req_valid),
    .req_o                  (req),
    .req_ready_i            (req_ready)
  );

  ohci_dma_request i_dma_request (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .req_valid_i            (req_valid),
    .req_i                  (req),
    .req_ready_o            (req_ready),
    .ratio_i                (ratio),
    .dma_valid_o            (dma_valid_o),
    .dma_req_o              (dma_req_o),
    .dma_ready_i            (dma_ready_i),
    .counter_is_threshold_o (counter_is_threshold)
  );

endmodule

// ==== verif/ohci_list_tb.sv ====
/* stimulus file is read from verif/ relative to the project root; DMA stalls come
   from a fixed-seed LFSR, expected DMA requests must be queued before their stimulus */
`timescale 1ns/10ps

module ohci_list_tb;
  import ohci_list_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 16;
  localparam int MAX_REC        = 64;
  localparam int CYCLES_PER_REC = 20;
  // record opcodes
  localparam logic [3:0] OP_WRITE  = 4'h1;
  localparam logic [3:0] OP_READ   = 4'h2;
  localparam logic [3:0] OP_PUSH   = 4'h3;
  localparam logic [3:0] OP_EXPECT = 4'h4;
  localparam logic [3:0] OP_START  = 4'h5;

  logic      clk_i;
  logic      rst_n_i;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic      start_i;
  logic      nextis_valid_i;
  nextis_t   nextis_item;
  logic      nextis_ready_o;
  logic      dma_valid_o;
  dma_req_t  dma_req_o;
  logic      dma_ready_i;

  // three words per record: {op, offset}, argument, expected
  logic [31:0] stim_mem [0:3*MAX_REC-1];
  // expected DMA requests, {address, channel, 0, is_ed}
  logic [31:0] exp_q [$];
  logic [31:0] lfsr;
  int          n_rec;
  int          cycle_limit;
  int          cycles;
  int          checks;
  int          errors;
  int          dma_seen;

  ohci_list_top uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .axil_req_i     (axil_req),
    .axil_rsp_o     (axil_rsp),
    .start_i        (start_i),
    .nextis_valid_i (nextis_valid_i),
    .nextis_i       (nextis_item),
    .nextis_ready_o (nextis_ready_o),
    .dma_valid_o    (dma_valid_o),
    .dma_req_o      (dma_req_o),
    .dma_ready_i    (dma_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // run limit scales with the record count
  initial begin
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (cycles <= cycle_limit);
    $display("timeout after %0d cycles, %0d DMA requests never arrived",
             cycles, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  // Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) lfsr_step = (state >> 1) ^ 32'h8020_0003;
    else lfsr_step = state >> 1;
  endfunction

  task automatic check_dma_req;
    logic [31:0] got;
    logic [31:0] want;
    got = {dma_req_o.address, dma_req_o.channel, 1'b0, dma_req_o.is_ed};
    dma_seen++;
    if (exp_q.size() == 0) begin
      $display("DMA request %h taken at %0t while none was expected", got, $time);
      errors++;
    end else begin
      want = exp_q.pop_front();
      checks++;
      if (got !== want) begin
        $display("[ERROR] dma_req_o: expected %h, got %h", want, got);
        errors++;
      end
    end
  endtask

  // DMA side, one stall bit per cycle
  initial begin
    dma_ready_i = 1'b0;
    lfsr        = 32'hd76f_7120;
    forever begin
      @(negedge clk_i);
      dma_ready_i = lfsr[0];
      lfsr        = lfsr_step(lfsr);
      // values seen here are the ones the next rising edge takes
      if (dma_valid_o && dma_ready_i) check_dma_req();
    end
  end

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    logic aw_go;
    logic w_go;
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    do begin
      aw_go = axil_req.awvalid && axil_rsp.awready;
      w_go  = axil_req.wvalid && axil_rsp.wready;
      @(negedge clk_i);
      if (aw_go) axil_req.awvalid = 1'b0;
      if (w_go) axil_req.wvalid = 1'b0;
    end while (axil_req.awvalid || axil_req.wvalid);
    while (!axil_rsp.bvalid) @(negedge clk_i);
    // bready held back one cycle, response has to wait for it
    axil_req.bready = 1'b0;
    checks++;
    if (axil_rsp.bresp !== exp_resp) begin
      $display("[ERROR] bresp at offset %h: expected %h, got %h", addr, exp_resp,
               axil_rsp.bresp);
      errors++;
    end
    @(negedge clk_i);
    checks++;
    if (!axil_rsp.bvalid) begin
      $display("write response at offset %h dropped before bready was set", addr);
      errors++;
    end
    // response leaves on the next edge
    axil_req.bready = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic axil_read(input logic [7:0] addr, input logic [1:0] exp_resp,
                           input logic [31:0] exp_data);
    logic ar_go;
    // pointer updates settle once all queued requests went out
    while (exp_q.size() != 0 || dma_valid_o) @(negedge clk_i);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do begin
      ar_go = axil_rsp.arready;
      @(negedge clk_i);
    end while (!ar_go);
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) @(negedge clk_i);
    checks++;
    if (axil_rsp.rdata !== exp_data || axil_rsp.rresp !== exp_resp) begin
      $display("[ERROR] rdata/rresp at offset %h: expected %h/%h, got %h/%h", addr,
               exp_data, exp_resp, axil_rsp.rdata, axil_rsp.rresp);
      errors++;
    end
    @(negedge clk_i);
  endtask

  task automatic push_item(input logic [31:0] item);
    logic go;
    nextis_item.address = item[31:4];
    nextis_item.channel = channel_e'(item[3:2]);
    nextis_item.is_ed   = item[0];
    nextis_valid_i      = 1'b1;
    // registered ready, stable at the falling edge
    do begin
      go = nextis_ready_o;
      @(negedge clk_i);
    end while (!go);
    nextis_valid_i = 1'b0;
  endtask

  task automatic pulse_start;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  task automatic run_record(input int idx);
    logic [3:0]  op;
    logic [7:0]  addr;
    logic [31:0] arg;
    logic [31:0] exp_val;
    op      = stim_mem[3*idx][11:8];
    addr    = stim_mem[3*idx][7:0];
    arg     = stim_mem[3*idx+1];
    exp_val = stim_mem[3*idx+2];
    case (op)
      OP_WRITE:  axil_write(addr, arg, exp_val[1:0]);
      OP_READ:   axil_read(addr, arg[1:0], exp_val);
      OP_PUSH:   push_item(arg);
      OP_EXPECT: exp_q.push_back(exp_val);
      OP_START:  pulse_start();
      default: begin
        $display("record %0d has unknown opcode %h", idx, op);
        errors++;
      end
    endcase
  endtask

  initial begin
    rst_n_i         = 1'b0;
    start_i         = 1'b0;
    nextis_valid_i  = 1'b0;
    nextis_item     = '0;
    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    checks          = 0;
    errors          = 0;
    dma_seen        = 0;
    for (int i = 0; i < 3 * MAX_REC; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verif/list_stimulus.hex", stim_mem);
    // opcode zero marks the end of the records
    n_rec = 0;
    while (n_rec < MAX_REC && stim_mem[3*n_rec][11:8] != 4'h0) n_rec++;
    cycle_limit = CYCLES_PER_REC * n_rec + RESET_CYCLES;
    if (n_rec == 0) begin
      $display("no stimulus records could be loaded");
      errors++;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int i = 0; i < n_rec; i++) begin
      run_record(i);
    end
    // drain, then a few idle cycles to catch stray requests
    while (exp_q.size() != 0 || dma_valid_o) @(negedge clk_i);
    repeat (8) @(negedge clk_i);
    $display("records %0d, checks %0d, dma requests %0d, errors %0d",
             n_rec, checks, dma_seen, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/list_stimulus.hex ====
// columns: {op, offset} argument expected; op 1 write (expected = bresp), 2 read (argument = rresp)
// op 3 nextis push, 4 queue expected DMA request, 5 start; items are {addr[31:4], chan, 0, is_ed}
// register round trip, low nibble reads zero
104 1234567F 00000000
204 00000000 12345670
10C 89ABCDE5 00000000
20C 00000000 89ABCDE0
114 00000339 00000000
214 00000000 00000330
118 DEADBEEF 00000002
218 00000002 00000000
100 FFFFFFFD 00000000
200 00000000 00000005
// start sends control head then bulk head
400 00000000 12345679
400 00000000 89ABCDED
500 00000000 00000000
208 00000000 12345670
210 00000000 89ABCDE0
// periodic frame, matching items pass unchanged
400 00000000 00000501
300 00000501 00000000
400 00000000 00000604
300 00000604 00000000
400 00000000 00000705
300 00000705 00000000
400 00000000 00000808
300 00000808 00000000
// control ED in a periodic frame resumes period current
400 00000000 00000705
300 00000909 00000000
214 00000000 00000700
// non periodic frame, ratio 1 so two control EDs before bulk
100 00000001 00000000
400 00000000 12345679
300 00000A01 00000000
400 00000000 12345679
300 00000B05 00000000
400 00000000 89ABCDED
300 00000C01 00000000
400 00000000 00000E09
300 00000E09 00000000
400 00000000 00000E09
300 00000D05 00000000
400 00000000 89ABCDED
300 00001001 00000000
400 00000000 00000F0D
300 00000F0D 00000000
208 00000000 00000E00
210 00000000 00000F00

// ==== files.f ====
rtl/ohci_list_pkg.sv
rtl/ohci_op_regs.sv
rtl/ohci_list_service.sv
rtl/ohci_dma_request.sv
rtl/ohci_list_top.sv
verif/ohci_list_tb.sv

// ==== Makefile ====
# Verilator build and run for the OHCI list scheduling core

VERILATOR ?= verilator
TOP       ?= ohci_list_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
